// File: design/socBus_cfg.svh
`ifndef SOCBUS_CFG_SVH
`define SOCBUS_CFG_SVH

// Bus widths, in words and byte lanes
`define BUS_ADDR_BITS 30
`define BUS_DATA_BITS 32
`define BUS_BYTE_LANES 4

// Selector field widths, from the top of the word address down
`define TOP_SEL_BITS 2
`define PERIPH_SEL_BITS 8
`define SMALL_SEL_BITS 10

// Top region codes
`define TOP_PERIPH 2'd3

// Peripheral block codes
`define PERIPH_RAM 8'd0
`define PERIPH_SMALL 8'd255

// Small peripheral codes
`define SMALL_GPIO 10'd2
`define SMALL_TIMER0 10'd9

// On-chip RAM size in words
`define RAM_DEPTH 1024

`endif

// File: design/socBusPkg.sv
`default_nettype none

package socBusPkg;

`include "socBus_cfg.svh"

    typedef logic [`BUS_DATA_BITS-1:0] busDataT;
    typedef logic [`BUS_BYTE_LANES-1:0] byteEnT;
    typedef logic [$clog2(`RAM_DEPTH)-1:0] ramIndexT;

    // Whatever is left of the word address below the three selectors
    typedef logic [`BUS_ADDR_BITS-`TOP_SEL_BITS-`PERIPH_SEL_BITS-`SMALL_SEL_BITS-1:0]
        smallRegAddrT;

    // Peripheral block view, used for the RAM window
    typedef struct packed {
        logic [`TOP_SEL_BITS-1:0] topSel;
        logic [`PERIPH_SEL_BITS-1:0] periphSel;
        logic [`BUS_ADDR_BITS-`TOP_SEL_BITS-`PERIPH_SEL_BITS-1:0] offset;
    } ramViewT;

    // Small peripheral view, one more selector level
    typedef struct packed {
        logic [`TOP_SEL_BITS-1:0] topSel;
        logic [`PERIPH_SEL_BITS-1:0] periphSel;
        logic [`SMALL_SEL_BITS-1:0] smallSel;
        smallRegAddrT regIndex;
    } smallViewT;

    // One word address, two decodes
    typedef union packed {
        ramViewT ramView;
        smallViewT smallView;
    } busAddrT;

endpackage

`default_nettype wire

// File: design/busFabric.sv
`timescale 1ns/1ns
`default_nettype none

`include "socBus_cfg.svh"

module busFabric (
    input  socBusPkg::busAddrT      i_busAddress,

    input  socBusPkg::busDataT      i_ramReadData,
    input  socBusPkg::busDataT      i_gpioReadData,
    input  socBusPkg::busDataT      i_timerReadData,
    input  logic                    i_ramWaitRequest,
    input  logic                    i_gpioWaitRequest,
    input  logic                    i_timerWaitRequest,

    output logic                    o_ramSel,
    output logic                    o_gpioSel,
    output logic                    o_timerSel,
    output socBusPkg::ramIndexT     o_ramIndex,
    output socBusPkg::smallRegAddrT o_smallRegAddr,

    output socBusPkg::busDataT      o_busReadData,
    output logic                    o_busWaitRequest
);

    logic w_topHit;
    logic w_ramBlockHit;
    logic w_smallBlockHit;

    // Top region select is shared by both views
    assign w_topHit = (i_busAddress.ramView.topSel == `TOP_PERIPH);

    // Peripheral block level
    assign w_ramBlockHit   = w_topHit && (i_busAddress.ramView.periphSel == `PERIPH_RAM);
    assign w_smallBlockHit = w_topHit &&
                             (i_busAddress.smallView.periphSel == `PERIPH_SMALL);

    // Slave selects
    assign o_ramSel   = w_ramBlockHit;
    assign o_gpioSel  = w_smallBlockHit && (i_busAddress.smallView.smallSel == `SMALL_GPIO);
    assign o_timerSel = w_smallBlockHit && (i_busAddress.smallView.smallSel == `SMALL_TIMER0);

    // RAM aliases across the rest of its 20-bit window
    assign o_ramIndex     = i_busAddress.ramView.offset[$clog2(`RAM_DEPTH)-1:0];
    assign o_smallRegAddr = i_busAddress.smallView.regIndex;

    // Idle slaves drive zero so unmapped reads return zero without a wait
    assign o_busReadData = i_ramReadData | i_gpioReadData | i_timerReadData;

    assign o_busWaitRequest = i_ramWaitRequest | i_gpioWaitRequest | i_timerWaitRequest;

    // Decode must never hit two slaves at once
    always_comb begin
        assert ($onehot0({o_ramSel, o_gpioSel, o_timerSel}))
            else $error("busFabric: more than one slave selected");
    end

endmodule

`default_nettype wire

// File: design/ramSlave.sv
`timescale 1ns/1ns
`default_nettype none

`include "socBus_cfg.svh"

module ramSlave (
    input  logic                w_SysClk,
    input  logic                i_reset,

    input  logic                i_sel,
    input  socBusPkg::ramIndexT i_index,
    input  socBusPkg::byteEnT   i_byteEn,
    input  logic                i_read,
    input  logic                i_write,
    input  socBusPkg::busDataT  i_writeData,

    output socBusPkg::busDataT  o_readData,
    output logic                o_waitRequest
);

    import socBusPkg::*;

    busDataT mem [0:`RAM_DEPTH-1];
    busDataT r_readData;
    logic    r_readPending;
    logic    w_readStart;

    // First cycle of a selected read
    assign w_readStart = i_sel && i_read && !r_readPending;

    always_ff @(posedge w_SysClk) begin
        if (i_reset) begin
            r_readPending <= 1'b0;
        end else begin
            r_readPending <= w_readStart;
        end
    end

    // Only the enabled lanes are written
    always_ff @(posedge w_SysClk) begin
        if (i_sel && i_write) begin
            for (int lane = 0; lane < `BUS_BYTE_LANES; lane++) begin
                if (i_byteEn[lane]) begin
                    mem[i_index][lane*8 +: 8] <= i_writeData[lane*8 +: 8];
                end
            end
        end
        if (w_readStart) begin
            r_readData <= mem[i_index];
        end
    end

    assign o_waitRequest = w_readStart;
    assign o_readData    = r_readPending ? r_readData : '0;

    // Master issues one command at a time
    assert property (@(posedge w_SysClk) disable iff (i_reset)
        i_sel |-> !(i_read && i_write))
        else $error("ramSlave: read and write together");

endmodule

`default_nettype wire

// File: design/gpioSevenSeg.sv
`timescale 1ns/1ns
`default_nettype none

module gpioSevenSeg (
    input  logic                    w_SysClk,
    input  logic                    i_reset,

    input  logic                    i_sel,
    input  socBusPkg::smallRegAddrT i_regAddr,
    input  socBusPkg::byteEnT       i_byteEn,
    input  logic                    i_read,
    input  logic                    i_write,
    input  socBusPkg::busDataT      i_writeData,

    output socBusPkg::busDataT      o_readData,
    output logic                    o_waitRequest,

    output logic [2:0]              o_sevenSegEn,
    output logic [6:0]              o_sevenSegLed
);

    import socBusPkg::*;

    logic [3:0] r_digit;
    logic [2:0] r_enMask;
    busDataT    r_readData;
    logic       r_readPending;
    logic       w_readStart;
    logic       w_regZero;
    busDataT    w_regValue;

    assign w_regZero   = (i_regAddr == '0);
    assign w_readStart = i_sel && i_read && !r_readPending;

    // Digit in bits 3:0, enable mask in bits 10:8
    assign w_regValue = {21'd0, r_enMask, 4'd0, r_digit};

    always_ff @(posedge w_SysClk) begin
        if (i_reset) begin
            r_digit       <= 4'd0;
            r_enMask      <= 3'd0;
            r_readPending <= 1'b0;
        end else begin
            r_readPending <= w_readStart;
            if (i_sel && i_write && w_regZero) begin
                if (i_byteEn[0]) begin
                    r_digit <= i_writeData[3:0];
                end
                if (i_byteEn[1]) begin
                    r_enMask <= i_writeData[10:8];
                end
            end
        end
    end

    always_ff @(posedge w_SysClk) begin
        if (w_readStart) begin
            r_readData <= w_regZero ? w_regValue : '0;
        end
    end

    assign o_waitRequest = w_readStart;
    assign o_readData    = r_readPending ? r_readData : '0;

    assign o_sevenSegEn = r_enMask;

    // Active low, segment a in bit 0
    always_comb begin
        case (r_digit)
            4'h0: o_sevenSegLed = ~7'h3F;
            4'h1: o_sevenSegLed = ~7'h06;
            4'h2: o_sevenSegLed = ~7'h5B;
            4'h3: o_sevenSegLed = ~7'h4F;
            4'h4: o_sevenSegLed = ~7'h66;
            4'h5: o_sevenSegLed = ~7'h6D;
            4'h6: o_sevenSegLed = ~7'h7D;
            4'h7: o_sevenSegLed = ~7'h07;
            4'h8: o_sevenSegLed = ~7'h7F;
            4'h9: o_sevenSegLed = ~7'h6F;
            4'hA: o_sevenSegLed = ~7'h77;
            4'hB: o_sevenSegLed = ~7'h7C;
            4'hC: o_sevenSegLed = ~7'h39;
            4'hD: o_sevenSegLed = ~7'h5E;
            4'hE: o_sevenSegLed = ~7'h79;
            default: o_sevenSegLed = ~7'h71;
        endcase
    end

endmodule

`default_nettype wire

// File: design/timerSlave.sv
`timescale 1ns/1ns
`default_nettype none

`include "socBus_cfg.svh"

module timerSlave (
    input  logic                    w_SysClk,
    input  logic                    i_reset,

    input  logic                    i_sel,
    input  socBusPkg::smallRegAddrT i_regAddr,
    input  socBusPkg::byteEnT       i_byteEn,
    input  logic                    i_read,
    input  logic                    i_write,
    input  socBusPkg::busDataT      i_writeData,

    output socBusPkg::busDataT      o_readData,
    output logic                    o_waitRequest
);

    import socBusPkg::*;

    localparam smallRegAddrT regCount   = 'd0;
    localparam smallRegAddrT regCompare = 'd1;
    localparam smallRegAddrT regStatus  = 'd2;
    localparam smallRegAddrT regControl = 'd3;

    busDataT r_count;
    busDataT r_compare;
    logic    r_matchFlag;
    logic    r_enable;
    busDataT r_readData;
    logic    r_readPending;
    logic    w_readStart;
    logic    w_wr;
    busDataT w_regValue;

    function automatic busDataT mergeBytes(busDataT oldWord, busDataT newWord, byteEnT en);
        busDataT result;
        result = oldWord;
        for (int lane = 0; lane < `BUS_BYTE_LANES; lane++) begin
            if (en[lane]) begin
                result[lane*8 +: 8] = newWord[lane*8 +: 8];
            end
        end
        return result;
    endfunction

    assign w_wr        = i_sel && i_write;
    assign w_readStart = i_sel && i_read && !r_readPending;

    always_ff @(posedge w_SysClk) begin
        if (i_reset) begin
            r_count       <= '0;
            r_compare     <= '0;
            r_matchFlag   <= 1'b0;
            r_enable      <= 1'b0;
            r_readPending <= 1'b0;
        end else begin
            r_readPending <= w_readStart;

            // A bus write to the count wins over the increment
            if (w_wr && i_regAddr == regCount) begin
                r_count <= mergeBytes(r_count, i_writeData, i_byteEn);
            end else if (r_enable) begin
                r_count <= r_count + 1'b1;
            end

            if (w_wr && i_regAddr == regCompare) begin
                r_compare <= mergeBytes(r_compare, i_writeData, i_byteEn);
            end

            // Sticky, a new match beats a clear in the same cycle
            if (r_enable && r_count == r_compare) begin
                r_matchFlag <= 1'b1;
            end else if (w_wr && i_regAddr == regStatus && i_byteEn[0] && i_writeData[0]) begin
                r_matchFlag <= 1'b0;
            end

            if (w_wr && i_regAddr == regControl && i_byteEn[0]) begin
                r_enable <= i_writeData[0];
            end
        end
    end

    always_comb begin
        case (i_regAddr)
            regCount:   w_regValue = r_count;
            regCompare: w_regValue = r_compare;
            regStatus:  w_regValue = {31'd0, r_matchFlag};
            regControl: w_regValue = {31'd0, r_enable};
            default:    w_regValue = '0;
        endcase
    end

    always_ff @(posedge w_SysClk) begin
        if (w_readStart) begin
            r_readData <= w_regValue;
        end
    end

    assign o_waitRequest = w_readStart;
    assign o_readData    = r_readPending ? r_readData : '0;

    // Match only comes from a running counter
    assert property (@(posedge w_SysClk) disable iff (i_reset)
        $rose(r_matchFlag) |-> $past(r_enable))
        else $error("timerSlave: match flag set while disabled");

endmodule

`default_nettype wire

// File: design/socBusTop.sv
`timescale 1ns/1ns
`default_nettype none

module socBusTop (
    input  logic               w_SysClk,
    input  logic               i_reset,

    // Data bus from the master
    input  socBusPkg::busAddrT i_busAddress,
    input  socBusPkg::byteEnT  i_busByteEn,
    input  logic               i_busRead,
    input  logic               i_busWrite,
    input  socBusPkg::busDataT i_busWriteData,
    output socBusPkg::busDataT o_busReadData,
    output logic               o_busWaitRequest,

    // Display pins
    output logic [2:0]         o_sevenSegEn,
    output logic [6:0]         o_sevenSegLed
);

    import socBusPkg::*;

    logic         w_ramSel;
    logic         w_gpioSel;
    logic         w_timerSel;
    ramIndexT     w_ramIndex;
    smallRegAddrT w_smallRegAddr;

    busDataT      w_ramReadData;
    busDataT      w_gpioReadData;
    busDataT      w_timerReadData;
    logic         w_ramWaitRequest;
    logic         w_gpioWaitRequest;
    logic         w_timerWaitRequest;

    busFabric busFabric_i (
        .i_busAddress       (i_busAddress),
        .i_ramReadData      (w_ramReadData),
        .i_gpioReadData     (w_gpioReadData),
        .i_timerReadData    (w_timerReadData),
        .i_ramWaitRequest   (w_ramWaitRequest),
        .i_gpioWaitRequest  (w_gpioWaitRequest),
        .i_timerWaitRequest (w_timerWaitRequest),
        .o_ramSel           (w_ramSel),
        .o_gpioSel          (w_gpioSel),
        .o_timerSel         (w_timerSel),
        .o_ramIndex         (w_ramIndex),
        .o_smallRegAddr     (w_smallRegAddr),
        .o_busReadData      (o_busReadData),
        .o_busWaitRequest   (o_busWaitRequest)
    );

    ramSlave ramSlave_i (
        .w_SysClk      (w_SysClk),
        .i_reset       (i_reset),
        .i_sel         (w_ramSel),
        .i_index       (w_ramIndex),
        .i_byteEn      (i_busByteEn),
        .i_read        (i_busRead),
        .i_write       (i_busWrite),
        .i_writeData   (i_busWriteData),
        .o_readData    (w_ramReadData),
        .o_waitRequest (w_ramWaitRequest)
    );

    gpioSevenSeg gpioSevenSeg_i (
        .w_SysClk      (w_SysClk),
        .i_reset       (i_reset),
        .i_sel         (w_gpioSel),
        .i_regAddr     (w_smallRegAddr),
        .i_byteEn      (i_busByteEn),
        .i_read        (i_busRead),
        .i_write       (i_busWrite),
        .i_writeData   (i_busWriteData),
        .o_readData    (w_gpioReadData),
        .o_waitRequest (w_gpioWaitRequest),
        .o_sevenSegEn  (o_sevenSegEn),
        .o_sevenSegLed (o_sevenSegLed)
    );

    timerSlave timerSlave_i (
        .w_SysClk      (w_SysClk),
        .i_reset       (i_reset),
        .i_sel         (w_timerSel),
        .i_regAddr     (w_smallRegAddr),
        .i_byteEn      (i_busByteEn),
        .i_read        (i_busRead),
        .i_write       (i_busWrite),
        .i_writeData   (i_busWriteData),
        .o_readData    (w_timerReadData),
        .o_waitRequest (w_timerWaitRequest)
    );

endmodule

`default_nettype wire

// File: sim/socBusTb.sv
`timescale 1ns/1ns
`default_nettype none

module socBusTb;

    import socBusPkg::*;

    localparam int clkHalfPeriod = 5;
    localparam int sampleDelay   = 2;
    localparam int resetCycles   = 5;
    localparam int waitLimit     = 20;
    localparam int pollLimit     = 100;

    logic       w_SysClk;
    logic       reset;
    busAddrT    busAddress;
    byteEnT     busByteEn;
    logic       readCmd;
    logic       writeCmd;
    busDataT    busWriteData;
    busDataT    busReadData;
    logic       busWaitRequest;
    logic [2:0] sevenSegEn;
    logic [6:0] sevenSegLed;

    socBusTop socBusTop_i (
        .w_SysClk         (w_SysClk),
        .i_reset          (reset),
        .i_busAddress     (busAddress),
        .i_busByteEn      (busByteEn),
        .i_busRead        (readCmd),
        .i_busWrite       (writeCmd),
        .i_busWriteData   (busWriteData),
        .o_busReadData    (busReadData),
        .o_busWaitRequest (busWaitRequest),
        .o_sevenSegEn     (sevenSegEn),
        .o_sevenSegLed    (sevenSegLed)
    );

    initial begin
        w_SysClk = 1'b0;
        forever begin
            #clkHalfPeriod w_SysClk = ~w_SysClk;
        end
    end

    task automatic reportFailure(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compareData(input string name, input busDataT actual, input busDataT expected);
        if (actual !== expected) begin
            reportFailure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic compareEnable(input string name, input logic [2:0] actual,
                                 input logic [2:0] expected);
        if (actual !== expected) begin
            reportFailure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic compareSegments(input string name, input logic [6:0] actual,
                                   input logic [6:0] expected);
        if (actual !== expected) begin
            reportFailure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic compareWaitCycles(input string name, input int actual, input int expected);
        if (actual != expected) begin
            reportFailure($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // Lit segments in gfedcba order and inverted for the active-low pins
    function automatic logic [6:0] segmentPattern(input logic [3:0] digit);
        logic [6:0] lit;
        case (digit)
            4'h0: lit = 7'b0111111;
            4'h1: lit = 7'b0000110;
            4'h2: lit = 7'b1011011;
            4'h3: lit = 7'b1001111;
            4'h4: lit = 7'b1100110;
            4'h5: lit = 7'b1101101;
            4'h6: lit = 7'b1111101;
            4'h7: lit = 7'b0000111;
            4'h8: lit = 7'b1111111;
            4'h9: lit = 7'b1101111;
            4'hA: lit = 7'b1110111;
            4'hB: lit = 7'b1111100;
            4'hC: lit = 7'b0111001;
            4'hD: lit = 7'b1011110;
            4'hE: lit = 7'b1111001;
            default: lit = 7'b1110001;
        endcase
        return ~lit;
    endfunction

    // Drive on the falling edge and sample in the low phase before the rising edge
    task automatic runTransfer(input logic isWrite, input busAddrT addr, input byteEnT byteEn,
                               input busDataT data, output busDataT readData,
                               output int waitCycles);
        logic done;
        @(negedge w_SysClk);
        busAddress   = addr;
        busByteEn    = byteEn;
        busWriteData = data;
        readCmd      = !isWrite;
        writeCmd     = isWrite;
        waitCycles   = 0;
        done         = 1'b0;
        while (!done && waitCycles <= waitLimit) begin
            #sampleDelay;
            if (busWaitRequest === 1'b0) begin
                done = 1'b1;
            end else begin
                waitCycles++;
                @(negedge w_SysClk);
            end
        end
        if (!done) begin
            reportFailure("Bus transfer did not complete before the wait timeout");
        end
        readData = busReadData;
        @(negedge w_SysClk);
        readCmd  = 1'b0;
        writeCmd = 1'b0;
    endtask

    task automatic writeWord(input busAddrT addr, input byteEnT byteEn, input busDataT data);
        busDataT unused;
        int      waitCycles;
        runTransfer(1'b1, addr, byteEn, data, unused, waitCycles);
        compareWaitCycles("o_busWaitRequest cycles on write", waitCycles, 0);
    endtask

    task automatic readWord(input busAddrT addr, input int expectedWait, output busDataT data);
        int waitCycles;
        runTransfer(1'b0, addr, 4'hF, '0, data, waitCycles);
        compareWaitCycles("o_busWaitRequest cycles on read", waitCycles, expectedWait);
    endtask

    initial begin
        int          fd;
        int          fields;
        int          polls;
        string       line;
        logic [7:0]  opChar;
        logic [31:0] vecAddr;
        logic [31:0] vecByteEn;
        logic [31:0] vecData;
        logic [31:0] vecExpected;
        busDataT     readValue;
        busDataT     firstCount;
        logic        matched;

        reset        = 1'b1;
        busAddress   = '0;
        busByteEn    = '0;
        readCmd      = 1'b0;
        writeCmd     = 1'b0;
        busWriteData = '0;

        for (int cycle = 0; cycle < resetCycles; cycle++) begin
            @(negedge w_SysClk);
        end
        reset = 1'b0;

        // Idle state straight out of reset
        #sampleDelay;
        if (busWaitRequest !== 1'b0) begin
            reportFailure($sformatf("ERROR o_busWaitRequest: got 0x%h, expected 0x0",
                                    busWaitRequest));
        end
        compareEnable("o_sevenSegEn", sevenSegEn, 3'b000);
        compareSegments("o_sevenSegLed", sevenSegLed, segmentPattern(4'h0));

        fd = $fopen("sim/socBusVectors.txt", "r");
        if (fd == 0) begin
            reportFailure("Could not open the vector file sim/socBusVectors.txt");
        end

        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            opChar = line.getc(0);
            fields = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h",
                             vecAddr, vecByteEn, vecData, vecExpected);
            if (fields != 4) begin
                reportFailure($sformatf("Malformed line in the vector file: %s", line));
            end
            case (opChar)
                "W": writeWord(vecAddr[29:0], vecByteEn[3:0], vecData);
                "R": begin
                    readWord(vecAddr[29:0], 1, readValue);
                    compareData("o_busReadData", readValue, vecExpected);
                end
                "U": begin
                    readWord(vecAddr[29:0], 0, readValue);
                    compareData("o_busReadData", readValue, vecExpected);
                end
                "D": begin
                    writeWord(vecAddr[29:0], vecByteEn[3:0], vecData);
                    #sampleDelay;
                    compareEnable("o_sevenSegEn", sevenSegEn, vecExpected[10:8]);
                    compareSegments("o_sevenSegLed", sevenSegLed,
                                    segmentPattern(vecExpected[3:0]));
                end
                "P": begin
                    matched = 1'b0;
                    polls   = 0;
                    while (!matched && polls < pollLimit) begin
                        readWord(vecAddr[29:0], 1, readValue);
                        matched = ((readValue & vecData) == vecExpected);
                        polls++;
                    end
                    if (!matched) begin
                        reportFailure("Polled register did not reach its value before the timeout");
                    end
                end
                "I": begin
                    readWord(vecAddr[29:0], 1, firstCount);
                    readWord(vecAddr[29:0], 1, readValue);
                    if (!(readValue > firstCount)) begin
                        reportFailure($sformatf("ERROR o_busReadData: count 0x%h after 0x%h",
                                                readValue, firstCount));
                    end
                end
                default: reportFailure("Unknown operation letter in the vector file");
            endcase
        end
        $fclose(fd);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/socBusVectors.txt
# op address byteEn data expected, all hex, address is the 30-bit word address
# W write, R read with one wait state, U unmapped read, D display write, P poll, I count rises
W 30000000 f 12345678 00000000
W 30000001 f deadbeef 00000000
W 300003ff f a5a55a5a 00000000
W 30000200 f 00000000 00000000
R 30000000 f 00000000 12345678
R 30000001 f 00000000 deadbeef
R 300003ff f 00000000 a5a55a5a
W 30000001 5 11223344 00000000
R 30000001 f 00000000 de22be44
W 30000000 8 ff000000 00000000
R 30000000 f 00000000 ff345678
W 30000200 6 abcdef01 00000000
R 30000200 f 00000000 00cdef00
U 00000010 f 00000000 00000000
U 10000020 f 00000000 00000000
U 3ff01400 f 00000000 00000000
W 3ff01400 f 12345678 00000000
U 3ff01400 f 00000000 00000000
R 3ff00800 f 00000000 00000000
D 3ff00800 3 00000700 00000700
R 3ff00800 f 00000000 00000700
D 3ff00800 3 00000101 00000101
D 3ff00800 3 00000202 00000202
D 3ff00800 3 00000303 00000303
D 3ff00800 3 00000404 00000404
D 3ff00800 3 00000505 00000505
D 3ff00800 3 00000606 00000606
D 3ff00800 3 00000707 00000707
D 3ff00800 3 00000108 00000108
D 3ff00800 3 00000209 00000209
D 3ff00800 3 0000030a 0000030a
D 3ff00800 3 0000040b 0000040b
D 3ff00800 3 0000050c 0000050c
D 3ff00800 3 0000060d 0000060d
D 3ff00800 3 0000070e 0000070e
D 3ff00800 3 0000010f 0000010f
R 3ff00800 f 00000000 0000010f
D 3ff00800 1 00000604 00000104
D 3ff00800 2 00000209 00000204
R 3ff00800 f 00000000 00000204
R 3ff00801 f 00000000 00000000
R 3ff02400 f 00000000 00000000
R 3ff02401 f 00000000 00000000
R 3ff02402 f 00000000 00000000
W 3ff02401 f 00000020 00000000
R 3ff02401 f 00000000 00000020
W 3ff02403 f 00000001 00000000
P 3ff02402 f 00000001 00000001
W 3ff02403 f 00000000 00000000
W 3ff02402 f 00000001 00000000
R 3ff02402 f 00000000 00000000
R 3ff02403 f 00000000 00000000
W 3ff02403 f 00000001 00000000
I 3ff02400 f 00000000 00000000
W 3ff02403 f 00000000 00000000

// File: build.f
+incdir+design
design/socBusPkg.sv
design/busFabric.sv
design/ramSlave.sv
design/gpioSevenSeg.sv
design/timerSlave.sv
design/socBusTop.sv
sim/socBusTb.sv

// File: run_sim.sh
#!/bin/sh
# Build the bus testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=socBusSim

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module socBusTb -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
runStatus=$?
cat "$LOG_FILE"
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG_FILE"; then
    exit 0
fi

echo "Pass message not found in $LOG_FILE"
exit 1
